//--- hw/sdram_test_pkg.sv
package sdram_test_pkg;

    ////////////////////////////////////////////////////////////
    // SDRAM geometry.
    ////////////////////////////////////////////////////////////

    // One SDRAM data word.
    localparam int word_w = 16;

    // Bank 2 + row 13 + column 9.
    localparam int addr_w = 24;

    localparam int burst_len = 4;       // Words per burst.

    ////////////////////////////////////////////////////////////
    // Serial report.
    ////////////////////////////////////////////////////////////

    localparam int byte_w = 8;          // One UART payload byte.

    // Sent instead of the high byte of a bad word.
    localparam logic [byte_w-1:0] err_code_hi = 8'hEE;

    // Sent instead of the low byte of a bad word.
    localparam logic [byte_w-1:0] err_code_lo = 8'hFF;

    ////////////////////////////////////////////////////////////
    // Data word views.
    ////////////////////////////////////////////////////////////

    // Same 16 bits seen two ways.
    // The checker compares the whole word.
    // The report reads its two bytes from the same storage.
    typedef union packed {
        logic [word_w-1:0]            word;     // Full word for compare.
        logic [1:0][byte_w-1:0]       bytes;    // [1] high, [0] low.
    } sdram_word_u;

endpackage

//--- hw/burst_pattern_checker.sv
`timescale 1ns/1ps

module burst_pattern_checker #(
    parameter int pass_gap_cycles = 2222222,    // Idle cycles between passes.
    parameter int num_passes      = 96000       // Bursts in one full run.
) (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    input  logic mem_wr_done,
    input  logic mem_rd_done,
    input  logic [sdram_test_pkg::burst_len-1:0][sdram_test_pkg::word_w-1:0] mem_rd_data,
    input  logic full,
    output logic mem_wr_req,
    output logic mem_rd_req,
    output logic [sdram_test_pkg::addr_w-1:0] mem_addr,
    output logic [sdram_test_pkg::burst_len-1:0][sdram_test_pkg::word_w-1:0] mem_wr_data,
    output logic push,
    output logic [sdram_test_pkg::byte_w-1:0] push_byte,
    output logic fault,
    output logic test_done
);

    localparam int gap_w  = (pass_gap_cycles > 1) ? $clog2(pass_gap_cycles) : 1;
    localparam int pass_w = (num_passes > 1) ? $clog2(num_passes) : 1;
    localparam int idx_w  = $clog2(2 * sdram_test_pkg::burst_len);   // Byte index in a burst.

    // FSM encoding.
    localparam logic [2:0] st_write  = 3'd0;
    localparam logic [2:0] st_read   = 3'd1;
    localparam logic [2:0] st_report = 3'd2;
    localparam logic [2:0] st_gap    = 3'd3;
    localparam logic [2:0] st_fault  = 3'd4;
    localparam logic [2:0] st_done   = 3'd5;

    logic [2:0]                        state;
    logic [gap_w-1:0]                  gap_cnt;     // Inter-pass delay.
    logic [pass_w-1:0]                 pass_cnt;    // Passes so far.
    logic [sdram_test_pkg::word_w-1:0] pass_val;    // Pass number mod 65536.
    logic [idx_w-1:0]                  byte_idx;    // Next report byte.
    logic [idx_w-2:0]                  word_idx;
    logic                              word_ok;
    logic                              last_byte;

    sdram_test_pkg::sdram_word_u rd_words [sdram_test_pkg::burst_len];   // Read-back burst.
    sdram_test_pkg::sdram_word_u cur_word;

    ////////////////////////////////////////////////////////////
    // Pattern and compare.
    ////////////////////////////////////////////////////////////

    // Word k carries pass value plus k.
    always_comb begin
        for (int k = 0; k < sdram_test_pkg::burst_len; k++) begin
            mem_wr_data[k] = pass_val + k[sdram_test_pkg::word_w-1:0];
        end
    end

    assign word_idx  = byte_idx[idx_w-1:1];             // Two bytes per word.
    assign cur_word  = rd_words[word_idx];
    assign word_ok   = (cur_word.word == mem_wr_data[word_idx]);
    assign last_byte = (byte_idx == idx_w'(2 * sdram_test_pkg::burst_len - 1));

    // One byte per cycle while the FIFO has room.
    assign push = (state == st_report) && !full;

    // High byte first, error codes in place of a bad word.
    always_comb begin
        if (word_ok) begin
            push_byte = byte_idx[0] ? cur_word.bytes[0] : cur_word.bytes[1];
        end else begin
            push_byte = byte_idx[0] ? sdram_test_pkg::err_code_lo
                                    : sdram_test_pkg::err_code_hi;
        end
    end

    // Capture the burst in the cycle of the done pulse.
    always_ff @(posedge clk_133MHz_210) begin
        if ((state == st_read) && mem_rd_req && mem_rd_done) begin
            for (int k = 0; k < sdram_test_pkg::burst_len; k++) begin
                rd_words[k].word <= mem_rd_data[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Pass sequencer.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_write;
            mem_wr_req <= 1'b0;
            mem_rd_req <= 1'b0;
            mem_addr   <= '0;
            pass_cnt   <= '0;
            pass_val   <= '0;
            byte_idx   <= '0;
            gap_cnt    <= '0;
            fault      <= 1'b0;
            test_done  <= 1'b0;
        end else begin
            case (state)
                st_write: begin
                    if (mem_wr_req && mem_wr_done) begin
                        mem_wr_req <= 1'b0;             // Drop after done.
                        mem_rd_req <= 1'b1;             // Read back at once.
                        state      <= st_read;
                    end else begin
                        mem_wr_req <= 1'b1;             // Hold until done.
                    end
                end
                st_read: begin
                    if (mem_rd_req && mem_rd_done) begin
                        mem_rd_req <= 1'b0;
                        byte_idx   <= '0;
                        state      <= st_report;
                    end
                end
                st_report: begin
                    if (!full) begin                    // Stall on full.
                        if (!word_ok && byte_idx[0]) begin
                            fault <= 1'b1;              // Both error codes sent.
                            state <= st_fault;
                        end else if (last_byte) begin
                            if (pass_cnt == pass_w'(num_passes - 1)) begin
                                test_done <= 1'b1;
                                state     <= st_done;
                            end else begin
                                gap_cnt <= '0;
                                state   <= st_gap;
                            end
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                st_gap: begin
                    if (gap_cnt == gap_w'(pass_gap_cycles - 1)) begin
                        pass_cnt <= pass_cnt + 1'b1;
                        pass_val <= pass_val + 1'b1;    // Move the pattern on.
                        mem_addr <= mem_addr
                                  + sdram_test_pkg::burst_len[sdram_test_pkg::addr_w-1:0];
                        state    <= st_write;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: begin
                    // Fault and done both halt here.
                end
            endcase
        end
    end

endmodule

//--- hw/report_byte_fifo.sv
`timescale 1ns/1ps

module report_byte_fifo #(
    parameter int fifo_depth = 16               // Bytes held.
) (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    input  logic push,
    input  logic [sdram_test_pkg::byte_w-1:0] push_byte,
    input  logic pop,
    output logic [sdram_test_pkg::byte_w-1:0] head_byte,
    output logic empty,
    output logic full
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam logic [ptr_w:0] depth_cnt = fifo_depth[ptr_w:0];

    logic [sdram_test_pkg::byte_w-1:0] store [fifo_depth];     // Circular byte store.
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;                    // Occupancy.
    logic             do_push;
    logic             do_pop;

    // Wrap at the last slot, any depth.
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty     = (count == '0);
    assign full      = (count == depth_cnt);
    assign head_byte = store[rd_ptr];           // Show-ahead read.

    ////////////////////////////////////////////////////////////
    // Storage.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210) begin
        if (do_push) begin
            store[wr_ptr] <= push_byte;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and count.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither.
            endcase
        end
    end

endmodule

//--- hw/uart_byte_tx.sv
`timescale 1ns/1ps

module uart_byte_tx #(
    parameter int clks_per_bit = 1157           // 133.33 MHz / 115200.
) (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    input  logic [sdram_test_pkg::byte_w-1:0] head_byte,
    input  logic empty,
    output logic pop,
    output logic uart_txd
);

    localparam int baud_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    // Start, data bits, stop. Index of the stop bit.
    localparam logic [3:0] stop_bit = 4'(sdram_test_pkg::byte_w + 1);

    logic                            busy;      // Frame in progress.
    logic [baud_w-1:0]               baud_cnt;
    logic [3:0]                      bit_cnt;   // Bit now on the line.
    logic [sdram_test_pkg::byte_w:0] shift;     // Data bits, then stop.
    logic                            baud_end;

    // Take the head byte once the line is free.
    assign pop      = !busy && !empty;
    assign baud_end = (baud_cnt == baud_w'(clks_per_bit - 1));

    ////////////////////////////////////////////////////////////
    // Shift register.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210) begin
        if (pop) begin
            shift <= {1'b1, head_byte};         // Stop bit on top.
        end else if (busy && baud_end && (bit_cnt != stop_bit)) begin
            shift <= {1'b1, shift[sdram_test_pkg::byte_w:1]};   // LSB first.
        end
    end

    ////////////////////////////////////////////////////////////
    // Bit timing and line.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b1;                   // Line idles high.
        end else if (pop) begin
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b0;                   // Start bit.
        end else if (busy) begin
            if (baud_end) begin
                baud_cnt <= '0;
                if (bit_cnt == stop_bit) begin
                    busy <= 1'b0;               // Stop bit done, line stays high.
                end else begin
                    uart_txd <= shift[0];
                    bit_cnt  <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/sdram_self_test.sv
`timescale 1ns/1ps

module sdram_self_test #(
    parameter int clks_per_bit    = 1157,       // 115200 baud at 133.33 MHz.
    parameter int pass_gap_cycles = 2222222,
    parameter int num_passes      = 96000,      // 384000 words in four-word bursts.
    parameter int fifo_depth      = 16
) (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    input  logic mem_wr_done,
    input  logic mem_rd_done,
    input  logic [sdram_test_pkg::burst_len-1:0][sdram_test_pkg::word_w-1:0] mem_rd_data,
    output logic mem_wr_req,
    output logic mem_rd_req,
    output logic [sdram_test_pkg::addr_w-1:0] mem_addr,
    output logic [sdram_test_pkg::burst_len-1:0][sdram_test_pkg::word_w-1:0] mem_wr_data,
    output logic uart_txd,
    output logic fault,                         // Fault LED.
    output logic test_done
);

    ////////////////////////////////////////////////////////////
    // Checker to FIFO to UART.
    ////////////////////////////////////////////////////////////

    logic                              push;
    logic [sdram_test_pkg::byte_w-1:0] push_byte;
    logic                              full;
    logic [sdram_test_pkg::byte_w-1:0] head_byte;
    logic                              empty;
    logic                              pop;

    burst_pattern_checker #(
        .pass_gap_cycles (pass_gap_cycles),
        .num_passes      (num_passes)
    ) burst_pattern_checker_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_wr_done    (mem_wr_done),
        .mem_rd_done    (mem_rd_done),
        .mem_rd_data    (mem_rd_data),
        .full           (full),
        .mem_wr_req     (mem_wr_req),
        .mem_rd_req     (mem_rd_req),
        .mem_addr       (mem_addr),
        .mem_wr_data    (mem_wr_data),
        .push           (push),
        .push_byte      (push_byte),
        .fault          (fault),
        .test_done      (test_done)
    );

    report_byte_fifo #(
        .fifo_depth (fifo_depth)
    ) report_byte_fifo_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .push           (push),
        .push_byte      (push_byte),
        .pop            (pop),
        .head_byte      (head_byte),
        .empty          (empty),
        .full           (full)
    );

    uart_byte_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_byte_tx_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .head_byte      (head_byte),
        .empty          (empty),
        .pop            (pop),
        .uart_txd       (uart_txd)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    input  logic restart,                       // One-cycle request for a fresh reset.
    output logic clk_133MHz_210,
    output logic rst_n
);

    logic [3:0] hold = 4'd8;                    // Reset cycles still to go.

    initial begin
        clk_133MHz_210 = 1'b0;
        rst_n          = 1'b1;                  // Falls at the first edge.
    end

    always #50 clk_133MHz_210 = ~clk_133MHz_210;   // 100 ns period.

    // Reset held low for 8 rising edges.
    always @(posedge clk_133MHz_210) begin
        if (restart) begin
            hold  <= 4'd7;
            rst_n <= 1'b0;
        end else if (hold != 4'd0) begin
            hold  <= hold - 4'd1;
            rst_n <= 1'b0;
        end else begin
            rst_n <= 1'b1;
        end
    end

endmodule

//--- dv/sdram_self_test_properties.sv
`timescale 1ns/1ps

module sdram_self_test_properties (
    input logic clk_133MHz_210,
    input logic rst_n,
    input logic mem_wr_req,
    input logic mem_rd_req,
    input logic mem_wr_done,
    input logic mem_rd_done,
    input logic [sdram_test_pkg::addr_w-1:0] mem_addr,
    input logic uart_txd
);

    ////////////////////////////////////////////////////////////
    // Request handshake.
    ////////////////////////////////////////////////////////////

    // One request at a time.
    req_exclusive: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(mem_wr_req && mem_rd_req))
        else $error("write and read requests high together");

    wr_req_held: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        (mem_wr_req && !mem_wr_done) |=> mem_wr_req)
        else $error("write request dropped before its done pulse");

    rd_req_held: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        (mem_rd_req && !mem_rd_done) |=> mem_rd_req)
        else $error("read request dropped before its done pulse");

    // Address frozen until the controller is done.
    addr_stable: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        ((mem_wr_req && !mem_wr_done) || (mem_rd_req && !mem_rd_done)) |=> $stable(mem_addr))
        else $error("address moved while a request was pending");

    ////////////////////////////////////////////////////////////
    // UART line.
    ////////////////////////////////////////////////////////////

    txd_idle_in_reset: assert property (@(posedge clk_133MHz_210)
        !rst_n |-> uart_txd)
        else $error("UART line not idle during reset");

endmodule

bind sdram_self_test sdram_self_test_properties sdram_self_test_properties_i (
    .clk_133MHz_210 (clk_133MHz_210),
    .rst_n          (rst_n),
    .mem_wr_req     (mem_wr_req),
    .mem_rd_req     (mem_rd_req),
    .mem_wr_done    (mem_wr_done),
    .mem_rd_done    (mem_rd_done),
    .mem_addr       (mem_addr),
    .uart_txd       (uart_txd)
);

//--- dv/sdram_self_test_tb.sv
`timescale 1ns/1ps

module sdram_self_test_tb;

    localparam int cpb       = 8;               // UART clocks per bit.
    localparam int passes    = 3;
    localparam int num_scen  = 4;
    localparam int wait_max  = 20000;           // Cycles per wait.
    localparam int lat_slots = 64;              // Latencies drawn up front.

    // Scenario table of name, corrupt enable, corrupt pass and corrupt word.
    string scen_name [num_scen] = '{"clean", "bad_p1_w2", "bad_p0_w0", "bad_p2_w3"};
    bit    scen_en   [num_scen] = '{1'b0, 1'b1, 1'b1, 1'b1};
    int    scen_pass [num_scen] = '{0, 1, 0, 2};
    int    scen_word [num_scen] = '{0, 2, 0, 3};

    logic clk_133MHz_210;
    logic rst_n;
    logic restart = 1'b0;
    logic mem_wr_done = 1'b0;
    logic mem_rd_done = 1'b0;
    logic [sdram_test_pkg::burst_len-1:0][sdram_test_pkg::word_w-1:0] mem_rd_data = '0;
    logic mem_wr_req;
    logic mem_rd_req;
    logic [sdram_test_pkg::addr_w-1:0] mem_addr;
    logic [sdram_test_pkg::burst_len-1:0][sdram_test_pkg::word_w-1:0] mem_wr_data;
    logic uart_txd;
    logic fault;
    logic test_done;

    int    value_errs = 0;                      // Wrong values.
    int    event_errs = 0;                      // Timeouts and framing.
    string cur_name;
    bit    cur_en;
    int    cur_pass;
    int    cur_word;

    tb_clock_gen tb_clock_gen_i (
        .restart        (restart),
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n)
    );

    sdram_self_test #(
        .clks_per_bit (cpb), .pass_gap_cycles (20), .num_passes (passes), .fifo_depth (16)
    ) sdram_self_test_i (.*);

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (exp === got) else begin
            $display("ERR %s %s expected %h actual %h", cur_name, what, exp, got);
            value_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // SDRAM controller model.
    ////////////////////////////////////////////////////////////

    logic [sdram_test_pkg::word_w-1:0] sdram_mem [256];
    logic [sdram_test_pkg::addr_w-1:0] last_wr_addr;
    int lat_tab [lat_slots];                    // Answer delays, 1 to 12.
    int lat_idx = 0;
    bit is_wr;
    bit busy;
    int lat;
    int wr_count;
    int rd_count;
    int req_count;

    always @(posedge clk_133MHz_210) begin
        mem_wr_done <= 1'b0;
        mem_rd_done <= 1'b0;
        if (!rst_n) begin
            busy      <= 1'b0;
            wr_count  <= 0;
            rd_count  <= 0;
            req_count <= 0;
        end else if (!busy) begin
            // Skip the cycle where the request is still up after done.
            if ((mem_wr_req || mem_rd_req) && !mem_wr_done && !mem_rd_done) begin
                busy      <= 1'b1;
                is_wr     <= mem_wr_req;
                lat       <= lat_tab[lat_idx];
                lat_idx   <= (lat_idx + 1) % lat_slots;
                req_count <= req_count + 1;
                if (mem_wr_req) begin
                    check_value("write address", 32'(4 * wr_count), 32'(mem_addr));
                    for (int k = 0; k < sdram_test_pkg::burst_len; k++) begin
                        check_value($sformatf("write word %0d", k),
                                    32'(16'(wr_count + k)), 32'(mem_wr_data[k]));
                    end
                    last_wr_addr <= mem_addr;
                end else begin
                    check_value("read address", 32'(last_wr_addr), 32'(mem_addr));
                end
            end
        end else if (lat > 1) begin
            lat <= lat - 1;
        end else begin
            busy <= 1'b0;
            if (is_wr) begin
                for (int k = 0; k < sdram_test_pkg::burst_len; k++) begin
                    sdram_mem[8'(mem_addr) + 8'(k)] <= mem_wr_data[k];
                end
                wr_count    <= wr_count + 1;
                mem_wr_done <= 1'b1;
            end else begin
                for (int k = 0; k < sdram_test_pkg::burst_len; k++) begin
                    mem_rd_data[k] <= sdram_mem[8'(mem_addr) + 8'(k)]
                                    ^ ((cur_en && rd_count == cur_pass && k == cur_word)
                                       ? 16'h0008 : 16'h0000);   // One flipped bit.
                end
                rd_count    <= rd_count + 1;
                mem_rd_done <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // UART receiver, mid-bit sampling.
    ////////////////////////////////////////////////////////////

    logic [7:0] rx_q [$];
    logic [7:0] rx_shift;
    bit rx_busy;
    int rx_cnt;
    int rx_bit;

    always @(negedge clk_133MHz_210) begin
        if (!rst_n) begin
            rx_busy = 1'b0;
        end else if (!rx_busy) begin
            if (!uart_txd) begin
                rx_busy = 1'b1;
                rx_cnt  = cpb / 2;              // First sample mid start bit.
                rx_bit  = 0;
            end
        end else if (rx_cnt < cpb - 1) begin
            rx_cnt++;
        end else begin
            rx_cnt = 0;
            if (rx_bit == 0) begin
                assert (!uart_txd) else begin
                    $display("Start bit too short on the UART line");
                    event_errs++;
                    rx_busy = 1'b0;
                end
            end else if (rx_bit <= 8) begin
                rx_shift[rx_bit-1] = uart_txd;  // LSB first.
            end else begin
                assert (uart_txd) else begin
                    $display("Missing stop bit on the UART line");
                    event_errs++;
                end
                rx_q.push_back(rx_shift);
                rx_busy = 1'b0;
            end
            rx_bit++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Scenario loop.
    ////////////////////////////////////////////////////////////

    initial begin
        logic [7:0] exp_q [$];
        logic [15:0] w;
        int n;
        int reqs;
        bit stop;
        void'($urandom(32'h46c6_dc92));
        for (int i = 0; i < lat_slots; i++) begin
            lat_tab[i] = 1 + int'($urandom % 12);
        end
        for (int s = 0; s < num_scen; s++) begin
            cur_name = scen_name[s];
            cur_en   = scen_en[s];
            cur_pass = scen_pass[s];
            cur_word = scen_word[s];
            @(posedge clk_133MHz_210);
            restart <= 1'b1;
            @(posedge clk_133MHz_210);
            restart <= 1'b0;
            for (n = 0; n < 20 && rst_n; n++) @(negedge clk_133MHz_210);
            if (rst_n) begin
                $display("Timeout in %s waiting for reset to assert", cur_name);
                event_errs++;
            end
            for (n = 0; n < 20 && !rst_n; n++) @(negedge clk_133MHz_210);
            if (!rst_n) begin
                $display("Timeout in %s waiting for reset to release", cur_name);
                event_errs++;
            end
            // Idle state after release, before the first request.
            check_value("wr_req after reset", 0, 32'(mem_wr_req));
            check_value("rd_req after reset", 0, 32'(mem_rd_req));
            check_value("fault after reset", 0, 32'(fault));
            check_value("test_done after reset", 0, 32'(test_done));
            check_value("uart_txd after reset", 1, 32'(uart_txd));
            rx_q.delete();

            // Expected stream from the pass rule.
            exp_q.delete();
            stop = 1'b0;
            for (int p = 0; p < passes && !stop; p++) begin
                for (int k = 0; k < sdram_test_pkg::burst_len && !stop; k++) begin
                    w = 16'(p + k);
                    if (cur_en && p == cur_pass && k == cur_word) begin
                        exp_q.push_back(8'hEE);
                        exp_q.push_back(8'hFF);
                        stop = 1'b1;
                    end else begin
                        exp_q.push_back(w[15:8]);
                        exp_q.push_back(w[7:0]);
                    end
                end
            end

            for (n = 0; n < wait_max && !test_done && !fault; n++) @(negedge clk_133MHz_210);
            if (n == wait_max) begin
                $display("Timeout in %s waiting for test_done or fault", cur_name);
                event_errs++;
            end
            reqs = req_count;
            for (n = 0; n < wait_max && rx_q.size() < exp_q.size(); n++) begin
                @(negedge clk_133MHz_210);
            end
            if (n == wait_max) begin
                $display("Timeout in %s waiting for report bytes", cur_name);
                event_errs++;
            end
            for (n = 0; n < 300; n++) @(negedge clk_133MHz_210);   // Quiet period.

            check_value("request count after end", 32'(reqs), 32'(req_count));
            check_value("fault", 32'(cur_en), 32'(fault));
            check_value("test_done", 32'(!cur_en), 32'(test_done));
            check_value("byte count", 32'(exp_q.size()), 32'(rx_q.size()));
            for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
                check_value($sformatf("byte %0d", i), 32'(exp_q[i]), 32'(rx_q[i]));
            end
        end

        $display("Errors: %0d value, %0d other", value_errs, event_errs);
        if (value_errs == 0 && event_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/sdram_test_pkg.sv
hw/burst_pattern_checker.sv
hw/report_byte_fifo.sv
hw/uart_byte_tx.sv
hw/sdram_self_test.sv
dv/tb_clock_gen.sv
dv/sdram_self_test_properties.sv
dv/sdram_self_test_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SDRAM self-test simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module sdram_self_test_tb \
    -o sim_bin
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
